// File: all.f
+incdir+logic
logic/mipsPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/hazardUnit.sv
logic/mipsCore.sv
testbench/mipsCore_assert.sv
testbench/mipsCoreTb.sv

// File: logic/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_cfg.svh"

module decodeStage
    import mipsPkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   stall,
    input  wire logic   flush,
    input  wire logic   forwardAD,
    input  wire logic   forwardBD,
    input  wire logic   regWriteW,
    input  wire wordT   instrD,
    input  wire wordT   pcPlus4D,
    input  wire wordT   aluResM,
    input  wire wordT   resultW,
    input  wire regIdxT destW,
    output logic        redirect,
    output wordT        redirectPc,
    output logic        isHalt,
    output logic        usesRt,
    output logic        isBranch,
    output logic        isJump,
    output regIdxT      rsD,
    output regIdxT      rtD,
    output ctrlT        ctrlE,
    output wordT        srcAE,
    output wordT        srcBE,
    output wordT        immE,
    output regIdxT      rsE,
    output regIdxT      rtE,
    output regIdxT      destE
);

    opcodeT op;
    functT  fn;
    ctrlT   ctrlD;
    logic   regDst;
    regIdxT rdD;
    regIdxT destD;
    wordT   immD;
    wordT   rdA;
    wordT   rdB;
    wordT   cmpA;
    wordT   cmpB;
    wordT   regs [`MIPS_NREGS];

    assign op    = opcodeT'(instrD[`MIPS_OP_LO +: `MIPS_OP_W]);
    assign fn    = functT'(instrD[`MIPS_FN_W-1:0]);
    assign rsD   = instrD[`MIPS_RS_LO +: `MIPS_RIDX];
    assign rtD   = instrD[`MIPS_RT_LO +: `MIPS_RIDX];
    assign rdD   = instrD[`MIPS_RD_LO +: `MIPS_RIDX];
    assign destD = regDst ? rdD : rtD;
    assign immD  = {{(`MIPS_XLEN-`MIPS_IMM_W){instrD[`MIPS_IMM_W-1]}},
                    instrD[`MIPS_IMM_W-1:0]};

    ////////////////////////////////////////////////////////////
    // control decode
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        ctrlD  = '0;   // unknown words fall through as bubbles
        regDst = 1'b0;
        case (op)
            rType:
            begin
                regDst         = 1'b1;
                ctrlD.regWrite = 1'b1;
                case (fn)
                    fAdd:    ctrlD.aluOp = aluAdd;
                    fSub:    ctrlD.aluOp = aluSub;
                    fAnd:    ctrlD.aluOp = aluAnd;
                    fOr:     ctrlD.aluOp = aluOr;
                    fSlt:    ctrlD.aluOp = aluSlt;
                    default: ctrlD.regWrite = 1'b0;   // nop and friends
                endcase
            end
            lw:
            begin
                ctrlD.regWrite = 1'b1;
                ctrlD.memToReg = 1'b1;
                ctrlD.aluSrc   = 1'b1;
            end
            sw:
            begin
                ctrlD.memWrite = 1'b1;
                ctrlD.aluSrc   = 1'b1;
            end
            addi:
            begin
                ctrlD.regWrite = 1'b1;
                ctrlD.aluSrc   = 1'b1;
            end
            halt:    ctrlD.halt = 1'b1;
            default: ;   // beq and j finish here in decode
        endcase
    end

    assign isHalt   = (op == halt);
    assign isBranch = (op == beq);
    assign isJump   = (op == j);
    assign usesRt   = (op == rType) || (op == sw) || (op == beq);

    // register file, r0 reads zero, writeback passes straight through
    always_ff @(posedge clk)
        if (regWriteW && destW != '0)
            regs[destW] <= resultW;

    assign rdA = (rsD == '0) ? '0 : (regWriteW && destW == rsD) ? resultW : regs[rsD];
    assign rdB = (rtD == '0) ? '0 : (regWriteW && destW == rtD) ? resultW : regs[rtD];

    // branch resolves here, operands may come from memory stage
    assign cmpA       = forwardAD ? aluResM : rdA;
    assign cmpB       = forwardBD ? aluResM : rdB;
    assign redirect   = !stall && ((isBranch && cmpA == cmpB) || isJump);
    assign redirectPc = isJump ? {pcPlus4D[`MIPS_XLEN-1 -: 4], instrD[`MIPS_JIDX_W-1:0], 2'b00}
                               : pcPlus4D + {immD[`MIPS_XLEN-3:0], 2'b00};

    ////////////////////////////////////////////////////////////
    // decode to execute
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            ctrlE <= '0;
        else if (flush)
            ctrlE <= '0;   // bubble
        else
            ctrlE <= ctrlD;
    end

    always_ff @(posedge clk)
    begin
        srcAE <= rdA;
        srcBE <= rdB;
        immE  <= immD;
        rsE   <= rsD;
        rtE   <= rtD;
        destE <= destD;
    end

endmodule

`default_nettype wire

// File: logic/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_cfg.svh"

module executeStage
    import mipsPkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [1:0] forwardA,
    input  wire logic [1:0] forwardB,
    input  wire ctrlT       ctrlE,
    input  wire wordT       srcAE,
    input  wire wordT       srcBE,
    input  wire wordT       immE,
    input  wire wordT       resultW,
    input  wire regIdxT     destE,
    output ctrlT            ctrlM,
    output wordT            aluResM,
    output wordT            writeDataM,
    output regIdxT          destM
);

    wordT opA;
    wordT regB;    // forwarded rt, also the store data
    wordT opB;
    wordT aluRes;
    logic lessThan;

    ////////////////////////////////////////////////////////////
    // operand forwarding
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (forwardA)
            2'b10:   opA = aluResM;   // memory stage
            2'b01:   opA = resultW;   // writeback
            default: opA = srcAE;
        endcase
    end

    always_comb
    begin
        case (forwardB)
            2'b10:   regB = aluResM;
            2'b01:   regB = resultW;
            default: regB = srcBE;
        endcase
    end

    assign opB = ctrlE.aluSrc ? immE : regB;

    // alu
    assign lessThan = $signed(opA) < $signed(opB);

    always_comb
    begin
        case (ctrlE.aluOp)
            aluSub:  aluRes = opA - opB;
            aluAnd:  aluRes = opA & opB;
            aluOr:   aluRes = opA | opB;
            aluSlt:  aluRes = {{(`MIPS_XLEN-1){1'b0}}, lessThan};
            default: aluRes = opA + opB;   // add, also lw and sw address
        endcase
    end

    // execute to memory
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            ctrlM <= '0;
        else
            ctrlM <= ctrlE;
    end

    always_ff @(posedge clk)
    begin
        aluResM    <= aluRes;
        writeDataM <= regB;
        destM      <= destE;
    end

endmodule

`default_nettype wire

// File: logic/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_cfg.svh"

module fetchStage
    import mipsPkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic stall,
    input  wire logic redirect,
    input  wire wordT redirectPc,
    input  wire wordT instr,
    output wordT      instrAddr,
    output wordT      instrD,
    output wordT      pcPlus4D
);

    wordT pc;
    wordT pcPlus4;

    assign pcPlus4   = pc + `MIPS_XLEN'd4;
    assign instrAddr = pc;   // rom answers in the same cycle

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            pc <= `MIPS_RESET_PC;
        else if (redirect)
            pc <= redirectPc;   // taken beq or j from decode
        else if (!stall)
            pc <= pcPlus4;
    end

    // fetch to decode, the word behind a redirect is squashed
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            instrD <= `MIPS_NOP;
        else if (redirect)
            instrD <= `MIPS_NOP;
        else if (!stall)
            instrD <= instr;
    end

    always_ff @(posedge clk)
        if (!stall)
            pcPlus4D <= pcPlus4;

endmodule

`default_nettype wire

// File: logic/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_cfg.svh"

module hazardUnit
    import mipsPkg::*;
(
    input  wire regIdxT rsD,
    input  wire regIdxT rtD,
    input  wire regIdxT rsE,
    input  wire regIdxT rtE,
    input  wire regIdxT destE,
    input  wire regIdxT destM,
    input  wire regIdxT destW,
    input  wire logic   usesRt,
    input  wire logic   isBranch,
    input  wire logic   isJump,
    input  wire logic   isHalt,
    input  wire ctrlT   ctrlE,
    input  wire ctrlT   ctrlM,
    input  wire ctrlT   ctrlW,
    output logic [1:0]  forwardA,
    output logic [1:0]  forwardB,
    output logic        forwardAD,
    output logic        forwardBD,
    output logic        stallF,
    output logic        stallD,
    output logic        flushE
);

    logic lwStall;
    logic branchStall;
    logic haltDown;   // halt already past decode
    logic holdFD;

    // memory stage wins over writeback, r0 never forwarded
    assign forwardA = (rsE != '0 && ctrlM.regWrite && rsE == destM) ? 2'b10 :
                      (rsE != '0 && ctrlW.regWrite && rsE == destW) ? 2'b01 : 2'b00;
    assign forwardB = (rtE != '0 && ctrlM.regWrite && rtE == destM) ? 2'b10 :
                      (rtE != '0 && ctrlW.regWrite && rtE == destW) ? 2'b01 : 2'b00;

    assign forwardAD = rsD != '0 && ctrlM.regWrite && rsD == destM;
    assign forwardBD = rtD != '0 && ctrlM.regWrite && rtD == destM;

    assign lwStall = ctrlE.memToReg && destE != '0 &&
                     (rsD == destE || (usesRt && rtD == destE));

    // beq compares in decode, so an alu result in execute or a load in memory is too late
    assign branchStall = isBranch &&
        ((ctrlE.regWrite && destE != '0 && (destE == rsD || destE == rtD)) ||
         (ctrlM.memToReg && destM != '0 && (destM == rsD || destM == rtD)));

    assign haltDown = ctrlE.halt || ctrlM.halt || ctrlW.halt;
    assign holdFD   = lwStall || branchStall || isHalt || haltDown;

    assign stallF = holdFD;
    assign stallD = holdFD;
    assign flushE = lwStall || branchStall || isJump || haltDown;

endmodule

`default_nettype wire

// File: logic/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_cfg.svh"

module mipsCore
    import mipsPkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    output wordT      instrAddr,
    input  wire wordT instr,
    output wordT      dataAddr,
    output wordT      dataWriteData,
    output logic      dataWriteEnable,
    input  wire wordT dataReadData,
    output logic      halted
);

    // fetch and decode
    wordT       instrD;
    wordT       pcPlus4D;
    logic       redirect;
    wordT       redirectPc;
    logic       isHalt, usesRt, isBranch, isJump;
    regIdxT     rsD, rtD;
    // execute
    ctrlT       ctrlE;
    wordT       srcAE, srcBE, immE;
    regIdxT     rsE, rtE, destE;
    // memory and writeback
    ctrlT       ctrlM;
    wordT       aluResM, writeDataM;
    regIdxT     destM;
    ctrlT       ctrlW;
    wordT       aluResW, readDataW, resultW;
    regIdxT     destW;
    logic       regWriteW;
    // hazard
    logic       stallF, stallD, flushE;
    logic [1:0] forwardA, forwardB;
    logic       forwardAD, forwardBD;

    fetchStage u_fetch (
        .clk(clk), .reset(reset), .stall(stallF),
        .redirect(redirect), .redirectPc(redirectPc),
        .instr(instr), .instrAddr(instrAddr),
        .instrD(instrD), .pcPlus4D(pcPlus4D)
    );

    decodeStage u_decode (
        .clk(clk), .reset(reset), .stall(stallD), .flush(flushE),
        .forwardAD(forwardAD), .forwardBD(forwardBD),
        .regWriteW(regWriteW), .instrD(instrD), .pcPlus4D(pcPlus4D),
        .aluResM(aluResM), .resultW(resultW), .destW(destW),
        .redirect(redirect), .redirectPc(redirectPc),
        .isHalt(isHalt), .usesRt(usesRt), .isBranch(isBranch), .isJump(isJump),
        .rsD(rsD), .rtD(rtD), .ctrlE(ctrlE),
        .srcAE(srcAE), .srcBE(srcBE), .immE(immE),
        .rsE(rsE), .rtE(rtE), .destE(destE)
    );

    executeStage u_execute (
        .clk(clk), .reset(reset), .forwardA(forwardA), .forwardB(forwardB),
        .ctrlE(ctrlE), .srcAE(srcAE), .srcBE(srcBE), .immE(immE),
        .resultW(resultW), .destE(destE), .ctrlM(ctrlM),
        .aluResM(aluResM), .writeDataM(writeDataM), .destM(destM)
    );

    hazardUnit u_hazard (
        .rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE),
        .destE(destE), .destM(destM), .destW(destW),
        .usesRt(usesRt), .isBranch(isBranch), .isJump(isJump), .isHalt(isHalt),
        .ctrlE(ctrlE), .ctrlM(ctrlM), .ctrlW(ctrlW),
        .forwardA(forwardA), .forwardB(forwardB),
        .forwardAD(forwardAD), .forwardBD(forwardBD),
        .stallF(stallF), .stallD(stallD), .flushE(flushE)
    );

    ////////////////////////////////////////////////////////////
    // memory stage, data ram answers in the same cycle
    ////////////////////////////////////////////////////////////

    assign dataAddr        = aluResM;
    assign dataWriteData   = writeDataM;
    assign dataWriteEnable = ctrlM.memWrite;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            ctrlW <= '0;
        else
            ctrlW <= ctrlM;
    end

    always_ff @(posedge clk)
    begin
        aluResW   <= aluResM;
        readDataW <= dataReadData;
        destW     <= destM;
    end

    // writeback
    assign resultW   = ctrlW.memToReg ? readDataW : aluResW;
    assign regWriteW = ctrlW.regWrite;

    // sticky, rises as the halt enters writeback
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            halted <= 1'b0;
        else if (ctrlM.halt)
            halted <= 1'b1;
    end

endmodule

`default_nettype wire

// File: logic/mipsCore_cfg.svh
`ifndef MIPS_CORE_CFG_SVH
`define MIPS_CORE_CFG_SVH

`define MIPS_XLEN     32            // data and address width
`define MIPS_NREGS    32
`define MIPS_RIDX     5
`define MIPS_RESET_PC 32'h0000_0000
`define MIPS_NOP      32'h0000_0000 // all-zero word, decodes to no operation

// instruction field positions
`define MIPS_OP_LO    26
`define MIPS_OP_W     6
`define MIPS_RS_LO    21
`define MIPS_RT_LO    16
`define MIPS_RD_LO    11
`define MIPS_FN_W     6
`define MIPS_IMM_W    16
`define MIPS_JIDX_W   26

`endif

// File: logic/mipsPkg.sv
`default_nettype none

`include "mipsCore_cfg.svh"

package mipsPkg;

    typedef logic [`MIPS_XLEN-1:0] wordT;
    typedef logic [`MIPS_RIDX-1:0] regIdxT;

    ////////////////////////////////////////////////////////////
    // instruction encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [`MIPS_OP_W-1:0] {
        rType = 6'b000000,
        j     = 6'b000010,
        beq   = 6'b000100,
        addi  = 6'b001000,
        halt  = 6'b001110,
        lw    = 6'b100011,
        sw    = 6'b101011
    } opcodeT;

    // function field of rType
    typedef enum logic [`MIPS_FN_W-1:0] {
        fAdd = 6'b100000,
        fSub = 6'b100010,
        fAnd = 6'b100100,
        fOr  = 6'b100101,
        fSlt = 6'b101010
    } functT;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,   // zero so that a cleared bundle adds
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOpT;

    ////////////////////////////////////////////////////////////
    // control bundle carried down the pipe
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  regWrite;
        logic  memToReg;   // writeback takes load data
        logic  memWrite;
        logic  aluSrc;     // B operand is the immediate
        aluOpT aluOp;
        logic  halt;
    } ctrlT;

endpackage

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the mipsCore testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module mipsCoreTb \
    -f all.f

./obj_dir/VmipsCoreTb | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
else
    exit 1
fi

// File: testbench/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_cfg.svh"

module mipsCoreTb
    import mipsPkg::*;
;

    logic        clk;
    logic        reset;
    logic [31:0] instrAddr;
    logic [31:0] instr;
    logic [31:0] dataAddr;
    logic [31:0] dataWriteData;
    logic        dataWriteEnable;
    logic [31:0] dataReadData;
    logic        halted;

    logic [31:0] rom [256];
    logic [31:0] ram [512];
    logic [31:0] stAddr [$];
    logic [31:0] stData [$];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] rngState;
    int          progIdx;
    int          errors;
    int          checks;

    mipsCore u_dut (
        .clk(clk), .reset(reset), .instrAddr(instrAddr), .instr(instr),
        .dataAddr(dataAddr), .dataWriteData(dataWriteData),
        .dataWriteEnable(dataWriteEnable), .dataReadData(dataReadData),
        .halted(halted)
    );

    always #5 clk = ~clk;

    // both memories answer in the same cycle
    assign instr        = rom[instrAddr[9:2]];
    assign dataReadData = ram[dataAddr[10:2]];

    always @(posedge clk)
    begin
        if (!reset && dataWriteEnable)
        begin
            stAddr.push_back(dataAddr);
            stData.push_back(dataWriteData);
            ram[dataAddr[10:2]] <= dataWriteData;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [31:0] ramFill(input logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_1234;   // differs per address
    endfunction

    function automatic logic [31:0] rFormat(input logic [4:0] rs, input logic [4:0] rt,
                                            input logic [4:0] rd, input logic [5:0] fn);
        return {6'b000000, rs, rt, rd, 5'b00000, fn};
    endfunction

    function automatic logic [31:0] iFormat(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jFormat(input logic [25:0] wordIdx);
        return {j, wordIdx};
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[progIdx] = word;
        progIdx++;
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    // reset held while the memories are refilled
    task automatic startProgram();
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < 256; i++)
            rom[i] = `MIPS_NOP;
        for (int i = 0; i < 512; i++)
            ram[i] <= ramFill(i * 4);
        progIdx = 0;
        expAddr.delete();
        expData.delete();
    endtask

    task automatic runAndCheck(input string name);
        int waited;
        int nStores;
        rom[progIdx] = {halt, 26'b0};
        repeat (10) @(negedge clk);
        checks++;
        if (instrAddr !== `MIPS_RESET_PC || halted !== 1'b0 || dataWriteEnable !== 1'b0)
        begin
            $display("ERR %0t: %s in reset pc %h halted %b write enable %b", $time, name,
                     instrAddr, halted, dataWriteEnable);
            errors++;
        end
        stAddr.delete();
        stData.delete();
        reset = 1'b0;
        waited = 0;
        while (!halted && waited < 400)
        begin
            @(negedge clk);
            waited++;
        end
        if (!halted)
        begin
            $display("%s: timed out waiting for the core to halt", name);
            errors++;
        end
        nStores = stAddr.size();
        // stays halted, nothing behind the halt reaches memory
        repeat (20)
        begin
            @(negedge clk);
            checks++;
            if (!halted)
            begin
                $display("ERR %0t: %s halted fell", $time, name);
                errors++;
            end
        end
        checks++;
        if (stAddr.size() != nStores || stAddr.size() != expAddr.size())
        begin
            $display("ERR %0t: %s saw %0d stores, expected %0d", $time, name,
                     stAddr.size(), expAddr.size());
            errors++;
        end
        for (int i = 0; i < stAddr.size() && i < expAddr.size(); i++)
        begin
            checks++;
            if (stAddr[i] !== expAddr[i] || stData[i] !== expData[i])
            begin
                $display("ERR %0t: %s store %0d got %h <- %h, expected %h <- %h", $time,
                         name, i, stAddr[i], stData[i], expAddr[i], expData[i]);
                errors++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic aluTest();
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] a;
        logic [31:0] b;
        startProgram();
        ra = nextRand();
        rb = nextRand();
        a  = sext16(ra[15:0]) + sext16(ra[31:16]);
        b  = sext16(rb[15:0]) + sext16(rb[31:16]);
        emit(iFormat(addi, 0, 1, ra[15:0]));   // two-step chains
        emit(iFormat(addi, 1, 1, ra[31:16]));
        emit(iFormat(addi, 0, 2, rb[15:0]));
        emit(iFormat(addi, 2, 2, rb[31:16]));
        emit(rFormat(1, 2, 3, fAdd));
        emit(rFormat(1, 2, 4, fSub));
        emit(rFormat(1, 2, 5, fAnd));
        emit(rFormat(1, 2, 6, fOr));
        emit(rFormat(1, 2, 7, fSlt));
        emit(rFormat(2, 1, 8, fSlt));
        emit(rFormat(1, 2, 0, fAdd));   // write to r0 is dropped
        emit(iFormat(sw, 0, 0, 16'h0118));   // r0 read right behind it
        for (int r = 3; r <= 8; r++)
            emit(iFormat(sw, 0, 5'(r), 16'(16'h0100 + (r - 3) * 4)));
        expectStore(32'h118, 32'h0);
        expectStore(32'h100, a + b);
        expectStore(32'h104, a - b);
        expectStore(32'h108, a & b);
        expectStore(32'h10c, a | b);
        expectStore(32'h110, {31'b0, $signed(a) < $signed(b)});
        expectStore(32'h114, {31'b0, $signed(b) < $signed(a)});
        runAndCheck("alu");
    endtask

    task automatic forwardTest();
        logic [31:0] rx;
        logic [31:0] x;
        startProgram();
        rx = nextRand();
        x  = sext16(rx[15:0]);
        emit(iFormat(addi, 0, 1, rx[15:0]));
        emit(rFormat(1, 1, 2, fAdd));   // distance one
        emit(rFormat(2, 1, 3, fAdd));   // one from r2, two from r1
        emit(rFormat(1, 3, 6, fAdd));
        emit(iFormat(sw, 0, 6, 16'h0200));   // store data from memory stage
        emit(iFormat(addi, 0, 4, rx[15:0]));
        emit(`MIPS_NOP);
        emit(`MIPS_NOP);
        emit(`MIPS_NOP);
        emit(rFormat(4, 4, 5, fAdd));   // independent reference
        emit(iFormat(sw, 0, 2, 16'h0204));
        emit(iFormat(sw, 0, 3, 16'h0208));
        emit(iFormat(sw, 0, 5, 16'h020c));
        expectStore(32'h200, x * 4);
        expectStore(32'h204, x * 2);
        expectStore(32'h208, x * 3);
        expectStore(32'h20c, x * 2);
        runAndCheck("forward");
    endtask

    task automatic loadUseTest();
        logic [31:0] rk;
        startProgram();
        rk = nextRand();
        emit(iFormat(addi, 0, 1, rk[15:0]));
        emit(iFormat(lw, 0, 2, 16'h0040));
        emit(rFormat(2, 1, 3, fAdd));   // needs the load right away
        emit(iFormat(sw, 0, 3, 16'h0300));
        emit(iFormat(lw, 0, 4, 16'h0044));
        emit(iFormat(sw, 0, 4, 16'h0304));
        expectStore(32'h300, ramFill(32'h40) + sext16(rk[15:0]));
        expectStore(32'h304, ramFill(32'h44));
        runAndCheck("loadUse");
    endtask

    task automatic branchTest();
        startProgram();
        emit(iFormat(addi, 0, 1, 16'd5));
        emit(iFormat(addi, 0, 2, 16'd5));
        emit(iFormat(beq, 1, 2, 16'd1));   // taken
        emit(iFormat(sw, 0, 1, 16'h0400));
        emit(iFormat(sw, 0, 2, 16'h0404));
        emit(iFormat(addi, 0, 3, 16'd6));
        emit(iFormat(beq, 1, 3, 16'd1));   // not taken
        emit(iFormat(sw, 0, 3, 16'h0408));
        emit(iFormat(addi, 0, 4, 16'd5));
        emit(iFormat(beq, 4, 1, 16'd1));   // operand from the previous word
        emit(iFormat(sw, 0, 4, 16'h040c));
        emit(iFormat(sw, 0, 1, 16'h0410));
        expectStore(32'h404, 32'd5);
        expectStore(32'h408, 32'd6);
        expectStore(32'h410, 32'd5);
        runAndCheck("branch");
    endtask

    task automatic jumpHaltTest();
        startProgram();
        emit(iFormat(addi, 0, 1, 16'd7));
        emit(jFormat(26'd4));
        emit(iFormat(sw, 0, 1, 16'h0500));
        emit(iFormat(sw, 0, 1, 16'h0504));
        emit(iFormat(sw, 0, 1, 16'h0508));   // jump target
        emit({halt, 26'b0});
        emit(iFormat(sw, 0, 1, 16'h050c));   // behind the halt
        emit(iFormat(sw, 0, 1, 16'h0510));
        expectStore(32'h508, 32'd7);
        runAndCheck("jumpHalt");
    endtask

    initial
    begin
        clk      = 1'b0;
        reset    = 1'b1;
        rngState = 32'h999e_bb2f;
        errors   = 0;
        checks   = 0;
        progIdx  = 0;
        for (int i = 0; i < 256; i++)
            rom[i] = `MIPS_NOP;
        aluTest();
        forwardTest();
        loadUseTest();
        branchTest();
        jumpHaltTest();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/mipsCore_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreAssert (
    input wire logic        clk,
    input wire logic        reset,
    input wire logic [31:0] instrAddr,
    input wire logic        dataWriteEnable,
    input wire logic        halted,
    input wire logic        stallF
);

    // no store may leave the core in reset or once it has stopped
    noStoreWhenIdle: assert property (@(posedge clk)
        (reset || halted) |-> !dataWriteEnable)
        else $error("data write enable high during reset or after halt");

    haltedSticky: assert property (@(posedge clk) disable iff (reset)
        !$fell(halted))
        else $error("halted dropped without reset");

    // a held fetch keeps the pc
    pcHeldOnStall: assert property (@(posedge clk) disable iff (reset)
        stallF |=> $stable(instrAddr))
        else $error("instruction address moved during a fetch stall");

endmodule

bind mipsCore mipsCoreAssert u_assert (
    .clk(clk), .reset(reset), .instrAddr(instrAddr),
    .dataWriteEnable(dataWriteEnable), .halted(halted), .stallF(stallF)
);

`default_nettype wire
